//--- sim.f
rtl/gw_input_pkg.sv
rtl/gw_lcd_pkg.sv
rtl/input_config_regs.sv
rtl/input_mapper.sv
rtl/cpu_clock_enable.sv
rtl/lcd_segment_latch.sv
rtl/lcd_segment_decay.sv
rtl/lcd_segment_lookup.sv
rtl/gw_frontend.sv
dv/gw_frontend_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = gw_frontend_tb
FILELIST = sim.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	! grep -q "Test failures found" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- dv/gw_frontend_tb.sv
`timescale 1ns/1ps

module gw_frontend_tb;

  localparam int DIVIDER_PERIOD = 4000;
  localparam int WAIT_LIMIT     = 2 * DIVIDER_PERIOD;

  // Codes that read a button in buttons_t order from the top bit down
  localparam logic [6:0] KNOWN_CODES [12] = '{
    7'd0, 7'd1, 7'd2, 7'd3, 7'd4, 7'd5, 7'd6, 7'd7, 7'd12, 7'd13, 7'd14, 7'd16
  };

  logic                        clk_sys_131_072;
  logic                        reset;
  gw_lcd_pkg::cpu_id_e         cpu_id;
  gw_input_pkg::buttons_t      buttons;
  logic                        cfg_wr;
  gw_input_pkg::config_slot_e  cfg_slot;
  gw_input_pkg::row_config_t   cfg_data;
  logic [7:0]                  shifter_s;
  logic [3:0]                  output_r;
  logic [1:0]                  lcd_h_index;
  gw_lcd_pkg::sm510_segments_t sm510_segments;
  gw_lcd_pkg::w_array_t        w_prime;
  gw_lcd_pkg::w_array_t        w_main;
  logic                        divider_1khz;
  logic                        vblank;
  gw_lcd_pkg::segment_id_t     segment_id;
  logic                        has_segment;
  logic                        clk_en;
  logic [3:0]                  input_k;
  logic                        input_beta;
  logic                        input_ba;
  logic                        segment_lit;

  // Reference state with segment words laid out as {a, b, bs}
  logic [31:0] row_model [8];
  logic [7:0]  beta_model;
  logic [7:0]  ba_model;
  logic [32:0] cache_model [4];
  logic [32:0] pending_model [4];
  int          decay_level;
  int          checks;
  int          errors;
  int          tests;
  int          errors_at_start;

  gw_frontend #(
    .DIVIDER_PERIOD (DIVIDER_PERIOD)
  ) u_gw_frontend (.*);

  initial begin
    clk_sys_131_072 = 1'b0;
    forever #2 clk_sys_131_072 = ~clk_sys_131_072;
  end

  // clk_en never stays high for two cycles in a row
  assert property (@(posedge clk_sys_131_072) clk_en |=> !clk_en)
    else begin
      $display("Pulse error at %0t ns: clk_en stayed high for more than one cycle", $time);
      errors++;
    end

  task automatic step();
    @(posedge clk_sys_131_072);
    #1;
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("Mismatch at %0t ns: %s expected 0x%0h, actual 0x%0h",
               $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic finish_test(string name);
    tests++;
    $display("Test %0d (%s) done with %0d errors", tests, name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  function automatic logic expected_level(logic [7:0] code_byte, logic [11:0] levels);
    logic level;
    level = 1'b0;
    for (int j = 0; j < 12; j++) begin
      if (code_byte[6:0] == KNOWN_CODES[j]) begin
        level = levels[11 - j];
      end
    end
    return level ^ code_byte[7];
  endfunction

  // Mostly real buttons with a few unused and unhandled codes
  function automatic logic [7:0] random_code();
    int         pick;
    logic [6:0] code;
    pick = $urandom_range(15);
    if (pick < 12) begin
      code = KNOWN_CODES[pick];
    end else if (pick == 12) begin
      code = 7'd127;
    end else begin
      code = 7'($urandom_range(127));
    end
    return {1'($urandom_range(1)), code};
  endfunction

  task automatic write_slot(int slot, logic [31:0] word);
    cfg_wr   = 1'b1;
    cfg_slot = gw_input_pkg::config_slot_e'(slot[3:0]);
    cfg_data = word;
    step();
    cfg_wr = 1'b0;
  endtask

  task automatic load_configs();
    for (int s = 0; s < 8; s++) begin
      row_model[s] = {random_code(), random_code(), random_code(), random_code()};
      write_slot(s, row_model[s]);
    end
    // Upper bytes carry junk that single-input slots drop
    beta_model = random_code();
    write_slot(8, {24'($urandom), beta_model});
    ba_model = random_code();
    write_slot(9, {24'($urandom), ba_model});
  endtask

  task automatic measure_pulse_gap();
    int gap;
    gap = 0;
    do begin
      step();
      gap++;
    end while (!clk_en && gap < WAIT_LIMIT);
    checks++;
    assert (clk_en) else begin
      $display("Timeout at %0t ns: no clk_en pulse within %0d cycles", $time, WAIT_LIMIT);
      errors++;
    end
    check_value("clk_en period", DIVIDER_PERIOD, gap);
  endtask

  task automatic check_mapping(logic use_sm5a, int count);
    int          row;
    logic [31:0] word;
    logic [3:0]  exp_k;
    for (int n = 0; n < count; n++) begin
      shifter_s = 8'($urandom) << (n % 9);
      output_r  = 4'($urandom);
      buttons   = gw_input_pkg::buttons_t'(12'($urandom));
      row = 0;
      if (use_sm5a) begin
        if (output_r[1]) begin
          row = 0;
        end else if (output_r[2]) begin
          row = 1;
        end else if (output_r[3]) begin
          row = 2;
        end
      end else begin
        while (row < 8 && !shifter_s[row]) begin
          row++;
        end
        if (row == 8) begin
          row = 0;
        end
      end
      word  = row_model[row];
      exp_k = {expected_level(word[31:24], buttons), expected_level(word[23:16], buttons),
               expected_level(word[15:8], buttons), expected_level(word[7:0], buttons)};
      step();
      check_value("input_k", exp_k, input_k);
      check_value("input_beta", expected_level(beta_model, buttons), input_beta);
      check_value("input_ba", expected_level(ba_model, buttons), input_ba);
    end
  endtask

  task automatic write_phase_words();
    for (int h = 0; h < 4; h++) begin
      pending_model[h] = {16'($urandom), 16'($urandom), 1'($urandom)};
      lcd_h_index      = 2'(h);
      sm510_segments   = pending_model[h];
      step();
    end
  endtask

  task automatic pulse_vblank();
    vblank = 1'b1;
    step();
    vblank = 1'b0;
    for (int h = 0; h < 4; h++) begin
      cache_model[h] = pending_model[h];
    end
  endtask

  task automatic check_lookups(logic present, int count);
    logic [32:0] word;
    logic        expected;
    for (int n = 0; n < count; n++) begin
      segment_id.line_select = 4'($urandom_range(3));
      segment_id.column      = 4'($urandom);
      segment_id.row         = 2'($urandom);
      has_segment            = present;
      #1;
      word = cache_model[segment_id.row];
      case (segment_id.line_select)
        4'd0: expected = word[17 + segment_id.column];
        4'd1: expected = word[1 + segment_id.column];
        4'd2: expected = word[0];
        default: expected = 1'b0;
      endcase
      check_value("segment_lit", present & expected, segment_lit);
      step();
    end
  endtask

  // One 1 kHz tick where the shown bit uses the level from before the step
  task automatic tick_decay(logic held);
    logic expected;
    expected = decay_level > 16;
    if (held && decay_level < 31) begin
      decay_level++;
    end else if (!held && decay_level > 0) begin
      decay_level--;
    end
    divider_1khz = 1'b1;
    step();
    divider_1khz = 1'b0;
    step();
    check_value("segment_lit", expected, segment_lit);
  endtask

  initial begin
    void'($urandom(32'h7004));
    checks          = 0;
    errors          = 0;
    tests           = 0;
    errors_at_start = 0;
    reset           = 1'b1;
    cpu_id          = gw_lcd_pkg::cpu_sm510;
    buttons         = '0;
    cfg_wr          = 1'b0;
    cfg_slot        = gw_input_pkg::slot_s0;
    cfg_data        = '0;
    shifter_s       = '0;
    output_r        = '0;
    lcd_h_index     = '0;
    sm510_segments  = '0;
    w_prime         = '0;
    w_main          = '0;
    divider_1khz    = 1'b0;
    vblank          = 1'b0;
    segment_id      = '0;
    has_segment     = 1'b0;
    for (int h = 0; h < 4; h++) begin
      cache_model[h]   = '0;
      pending_model[h] = '0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reset and divider
    for (int c = 0; c < 16; c++) begin
      step();
      check_value("clk_en", 1'b0, clk_en);
    end
    reset = 1'b0;
    measure_pulse_gap();
    measure_pulse_gap();
    finish_test("clk_en divider");

    ////////////////////////////////////////////////////////////////////////////
    // Input mapping
    load_configs();
    check_mapping(1'b0, 48);
    finish_test("sm510 input mapping");
    cpu_id = gw_lcd_pkg::cpu_sm5a;
    check_mapping(1'b1, 48);
    finish_test("sm5a input mapping");

    ////////////////////////////////////////////////////////////////////////////
    // LCD paths
    cpu_id = gw_lcd_pkg::cpu_sm510;
    write_phase_words();
    pulse_vblank();
    write_phase_words();
    // New words are latched but the cache still holds the old frame
    check_lookups(1'b1, 24);
    pulse_vblank();
    check_lookups(1'b1, 24);
    check_lookups(1'b0, 8);
    finish_test("sm510 segment cache");

    cpu_id      = gw_lcd_pkg::cpu_sm5a;
    lcd_h_index = 2'd0;
    w_main[5][2] = 1'b1;
    segment_id  = '{line_select: 4'd5, column: 4'd2, row: 2'd0};
    has_segment = 1'b1;
    decay_level = 0;
    step();
    for (int t = 0; t < 20; t++) begin
      tick_decay(1'b1);
    end
    segment_id.row = 2'd1;
    #1;
    check_value("segment_lit", 1'b0, segment_lit);
    segment_id.row = 2'd0;
    w_main = '0;
    step();
    for (int t = 0; t < 8; t++) begin
      tick_decay(1'b0);
    end
    finish_test("sm5a segment decay");

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- rtl/gw_frontend.sv
`timescale 1ns/1ps

module gw_frontend #(
  parameter int DIVIDER_PERIOD = 4000
) (
  input  logic                        clk_sys_131_072,
  input  logic                        reset,
  input  gw_lcd_pkg::cpu_id_e         cpu_id,
  input  gw_input_pkg::buttons_t      buttons,
  input  logic                        cfg_wr,
  input  gw_input_pkg::config_slot_e  cfg_slot,
  input  gw_input_pkg::row_config_t   cfg_data,
  input  logic [7:0]                  shifter_s,
  input  logic [3:0]                  output_r,
  input  logic [1:0]                  lcd_h_index,
  input  gw_lcd_pkg::sm510_segments_t sm510_segments,
  input  gw_lcd_pkg::w_array_t        w_prime,
  input  gw_lcd_pkg::w_array_t        w_main,
  input  logic                        divider_1khz,
  input  logic                        vblank,
  input  gw_lcd_pkg::segment_id_t     segment_id,
  input  logic                        has_segment,
  output logic                        clk_en,
  output logic [3:0]                  input_k,
  output logic                        input_beta,
  output logic                        input_ba,
  output logic                        segment_lit
);

  gw_input_pkg::row_config_t [7:0]   row_configs;
  gw_input_pkg::input_code_t         beta_code;
  gw_input_pkg::input_code_t         ba_code;
  gw_lcd_pkg::sm510_segments_t [3:0] cached_segments;
  gw_lcd_pkg::w_array_t              shown_w_prime;
  gw_lcd_pkg::w_array_t              shown_w_main;

  ////////////////////////////////////////////////////////////////////////////
  // Input path

  input_config_regs u_input_config_regs (
    .clk_sys_131_072 (clk_sys_131_072),
    .reset           (reset),
    .cfg_wr          (cfg_wr),
    .cfg_slot        (cfg_slot),
    .cfg_data        (cfg_data),
    .row_configs     (row_configs),
    .beta_code       (beta_code),
    .ba_code         (ba_code)
  );

  input_mapper u_input_mapper (
    .clk_sys_131_072 (clk_sys_131_072),
    .reset           (reset),
    .cpu_id          (cpu_id),
    .buttons         (buttons),
    .row_configs     (row_configs),
    .beta_code       (beta_code),
    .ba_code         (ba_code),
    .shifter_s       (shifter_s),
    .output_r        (output_r),
    .input_k         (input_k),
    .input_beta      (input_beta),
    .input_ba        (input_ba)
  );

  cpu_clock_enable #(
    .DIVIDER_PERIOD (DIVIDER_PERIOD)
  ) u_cpu_clock_enable (
    .clk_sys_131_072 (clk_sys_131_072),
    .reset           (reset),
    .clk_en          (clk_en)
  );

  ////////////////////////////////////////////////////////////////////////////
  // LCD path

  lcd_segment_latch u_lcd_segment_latch (
    .clk_sys_131_072 (clk_sys_131_072),
    .reset           (reset),
    .lcd_h_index     (lcd_h_index),
    .sm510_segments  (sm510_segments),
    .vblank          (vblank),
    .cached_segments (cached_segments)
  );

  lcd_segment_decay u_lcd_segment_decay (
    .clk_sys_131_072 (clk_sys_131_072),
    .reset           (reset),
    .lcd_h_index     (lcd_h_index),
    .w_prime         (w_prime),
    .w_main          (w_main),
    .tick_1khz       (divider_1khz),
    .shown_w_prime   (shown_w_prime),
    .shown_w_main    (shown_w_main)
  );

  lcd_segment_lookup u_lcd_segment_lookup (
    .cpu_id          (cpu_id),
    .segment_id      (segment_id),
    .has_segment     (has_segment),
    .cached_segments (cached_segments),
    .shown_w_prime   (shown_w_prime),
    .shown_w_main    (shown_w_main),
    .segment_lit     (segment_lit)
  );

endmodule

//--- rtl/lcd_segment_lookup.sv
`timescale 1ns/1ps

module lcd_segment_lookup (
  input  gw_lcd_pkg::cpu_id_e               cpu_id,
  input  gw_lcd_pkg::segment_id_t           segment_id,
  input  logic                              has_segment,
  input  gw_lcd_pkg::sm510_segments_t [3:0] cached_segments,
  input  gw_lcd_pkg::w_array_t              shown_w_prime,
  input  gw_lcd_pkg::w_array_t              shown_w_main,
  output logic                              segment_lit
);

  logic digit_valid;

  // Only 9 digits of 4 bits exist on the SM5a
  assign digit_valid = (segment_id.line_select < 4'd9) && (segment_id.column < 4'd4);

  always_comb begin
    segment_lit = 1'b0;
    if (has_segment) begin
      case (cpu_id)
        gw_lcd_pkg::cpu_sm5a: begin
          if (digit_valid) begin
            if (segment_id.row == 2'd1) begin
              segment_lit = shown_w_prime[segment_id.line_select][segment_id.column[1:0]];
            end else begin
              segment_lit = shown_w_main[segment_id.line_select][segment_id.column[1:0]];
            end
          end
        end
        default: begin
          // Row is the H phase, column the bit in the word
          case (segment_id.line_select)
            4'd0: segment_lit = cached_segments[segment_id.row].segment_a[segment_id.column];
            4'd1: segment_lit = cached_segments[segment_id.row].segment_b[segment_id.column];
            4'd2: segment_lit = cached_segments[segment_id.row].bs;
            default: segment_lit = 1'b0;
          endcase
        end
      endcase
    end
  end

endmodule

//--- rtl/lcd_segment_decay.sv
`timescale 1ns/1ps

module lcd_segment_decay (
  input  logic                 clk_sys_131_072,
  input  logic                 reset,
  input  logic [1:0]           lcd_h_index,
  input  gw_lcd_pkg::w_array_t w_prime,
  input  gw_lcd_pkg::w_array_t w_main,
  input  logic                 tick_1khz,
  output gw_lcd_pkg::w_array_t shown_w_prime,
  output gw_lcd_pkg::w_array_t shown_w_main
);

  localparam int         NUM_BITS       = 72;
  localparam logic [4:0] DECAY_MAX      = 5'd31;
  localparam logic [4:0] SHOW_THRESHOLD = 5'd16;

  gw_lcd_pkg::w_array_t  captured_prime;
  gw_lcd_pkg::w_array_t  captured_main;
  logic                  tick_q;
  logic                  tick_rise;
  logic [NUM_BITS-1:0]   captured_bits;
  logic [NUM_BITS-1:0]   shown_bits;

  assign tick_rise     = tick_1khz && !tick_q;
  assign captured_bits = {captured_prime, captured_main};

  // Odd H phases drive W', even ones W
  always_ff @(posedge clk_sys_131_072) begin
    if (reset) begin
      captured_prime <= '0;
      captured_main  <= '0;
      tick_q         <= 1'b0;
    end else begin
      tick_q <= tick_1khz;
      if (lcd_h_index[0]) begin
        captured_prime <= w_prime;
      end else begin
        captured_main <= w_main;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Persistence counters, W' in the upper half

  for (genvar i = 0; i < NUM_BITS; i++) begin : g_cell
    logic [4:0] level;
    logic       shown;

    always_ff @(posedge clk_sys_131_072) begin
      if (reset) begin
        level <= '0;
        shown <= 1'b0;
      end else if (tick_rise) begin
        // Uses the level from before this step, one tick behind
        shown <= level > SHOW_THRESHOLD;
        if (captured_bits[i] && level != DECAY_MAX) begin
          level <= level + 5'd1;
        end else if (!captured_bits[i] && level != 5'd0) begin
          level <= level - 5'd1;
        end
      end
    end

    assign shown_bits[i] = shown;
  end

  assign shown_w_prime = shown_bits[NUM_BITS-1:NUM_BITS/2];
  assign shown_w_main  = shown_bits[NUM_BITS/2-1:0];

endmodule

//--- rtl/lcd_segment_latch.sv
`timescale 1ns/1ps

module lcd_segment_latch (
  input  logic                                clk_sys_131_072,
  input  logic                                reset,
  input  logic [1:0]                          lcd_h_index,
  input  gw_lcd_pkg::sm510_segments_t         sm510_segments,
  input  logic                                vblank,
  output gw_lcd_pkg::sm510_segments_t [3:0]   cached_segments
);

  // Last words seen in each H phase
  gw_lcd_pkg::sm510_segments_t [3:0] latched;
  logic                              vblank_q;
  logic                              frame_start;

  assign frame_start = vblank && !vblank_q;

  always_ff @(posedge clk_sys_131_072) begin
    if (reset) begin
      latched         <= '0;
      cached_segments <= '0;
      vblank_q        <= 1'b0;
    end else begin
      vblank_q <= vblank;
      latched[lcd_h_index] <= sm510_segments;

      // Snapshot once per frame so the picture does not tear
      if (frame_start) begin
        cached_segments <= latched;
      end
    end
  end

endmodule

//--- rtl/cpu_clock_enable.sv
`timescale 1ns/1ps

module cpu_clock_enable #(
  parameter int DIVIDER_PERIOD = 4000
) (
  input  logic clk_sys_131_072,
  input  logic reset,
  output logic clk_en
);

  localparam int COUNT_WIDTH = $clog2(DIVIDER_PERIOD);
  localparam logic [COUNT_WIDTH-1:0] RELOAD = COUNT_WIDTH'(DIVIDER_PERIOD - 1);

  logic [COUNT_WIDTH-1:0] count;

  // Pulse lands the cycle after the counter hits zero
  always_ff @(posedge clk_sys_131_072) begin
    if (reset) begin
      count  <= RELOAD;
      clk_en <= 1'b0;
    end else if (count == '0) begin
      count  <= RELOAD;
      clk_en <= 1'b1;
    end else begin
      count  <= count - 1'b1;
      clk_en <= 1'b0;
    end
  end

endmodule

//--- rtl/input_mapper.sv
`timescale 1ns/1ps

module input_mapper (
  input  logic                            clk_sys_131_072,
  input  logic                            reset,
  input  gw_lcd_pkg::cpu_id_e             cpu_id,
  input  gw_input_pkg::buttons_t          buttons,
  input  gw_input_pkg::row_config_t [7:0] row_configs,
  input  gw_input_pkg::input_code_t       beta_code,
  input  gw_input_pkg::input_code_t       ba_code,
  input  logic [7:0]                      shifter_s,
  input  logic [3:0]                      output_r,
  output logic [3:0]                      input_k,
  output logic                            input_beta,
  output logic                            input_ba
);

  gw_input_pkg::row_config_t active_row;

  // Code to button level, invert flag applied last
  function automatic logic map_code(gw_input_pkg::input_code_t c,
                                    gw_input_pkg::buttons_t b);
    logic level;
    case (c.code)
      gw_input_pkg::btn_up:     level = b.up;
      gw_input_pkg::btn_down:   level = b.down;
      gw_input_pkg::btn_left:   level = b.left;
      gw_input_pkg::btn_right:  level = b.right;
      gw_input_pkg::btn_b:      level = b.b;
      gw_input_pkg::btn_a:      level = b.a;
      gw_input_pkg::btn_y:      level = b.y;
      gw_input_pkg::btn_x:      level = b.x;
      // Select doubles as Time, trig_r as Alarm
      gw_input_pkg::btn_trig_l: level = b.trig_l;
      gw_input_pkg::btn_select: level = b.select;
      gw_input_pkg::btn_start:  level = b.start;
      gw_input_pkg::btn_trig_r: level = b.trig_r;
      default:                  level = 1'b0;
    endcase
    return c.invert ? ~level : level;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Row selection

  always_comb begin
    active_row = row_configs[0];
    case (cpu_id)
      gw_lcd_pkg::cpu_sm5a: begin
        // R1 has priority over R2, R2 over R3
        if (output_r[1]) begin
          active_row = row_configs[0];
        end else if (output_r[2]) begin
          active_row = row_configs[1];
        end else if (output_r[3]) begin
          active_row = row_configs[2];
        end
      end
      default: begin
        // Lowest set S bit wins
        for (int i = 7; i >= 0; i--) begin
          if (shifter_s[i]) begin
            active_row = row_configs[i];
          end
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registered outputs to the CPU

  always_ff @(posedge clk_sys_131_072) begin
    if (reset) begin
      input_k    <= 4'b0;
      input_beta <= 1'b0;
      input_ba   <= 1'b0;
    end else begin
      input_k <= {
        map_code(active_row.k3, buttons),
        map_code(active_row.k2, buttons),
        map_code(active_row.k1, buttons),
        map_code(active_row.k0, buttons)
      };
      input_beta <= map_code(beta_code, buttons);
      input_ba   <= map_code(ba_code, buttons);
    end
  end

endmodule

//--- rtl/input_config_regs.sv
`timescale 1ns/1ps

module input_config_regs (
  input  logic                            clk_sys_131_072,
  input  logic                            reset,
  input  logic                            cfg_wr,
  input  gw_input_pkg::config_slot_e      cfg_slot,
  input  gw_input_pkg::row_config_t       cfg_data,
  output gw_input_pkg::row_config_t [7:0] row_configs,
  output gw_input_pkg::input_code_t       beta_code,
  output gw_input_pkg::input_code_t       ba_code
);

  always_ff @(posedge clk_sys_131_072) begin
    if (reset) begin
      row_configs <= {8{gw_input_pkg::ROW_UNUSED}};
      beta_code   <= gw_input_pkg::CODE_UNUSED;
      ba_code     <= gw_input_pkg::CODE_UNUSED;
    end else if (cfg_wr) begin
      case (cfg_slot)
        gw_input_pkg::slot_s0, gw_input_pkg::slot_s1,
        gw_input_pkg::slot_s2, gw_input_pkg::slot_s3,
        gw_input_pkg::slot_s4, gw_input_pkg::slot_s5,
        gw_input_pkg::slot_s6, gw_input_pkg::slot_s7: begin
          row_configs[cfg_slot[2:0]] <= cfg_data;
        end
        // Single-input slots only keep the low byte
        gw_input_pkg::slot_beta: beta_code <= cfg_data.k0;
        gw_input_pkg::slot_ba:   ba_code   <= cfg_data.k0;
        default: begin
        end
      endcase
    end
  end

endmodule

//--- rtl/gw_lcd_pkg.sv
package gw_lcd_pkg;

  // Anything not listed behaves as SM510
  typedef enum logic [3:0] {
    cpu_sm510 = 4'd0,
    cpu_sm5a  = 4'd4
  } cpu_id_e;

  // Segment outputs for one H phase
  typedef struct packed {
    logic [15:0] segment_a;
    logic [15:0] segment_b;
    logic        bs;
  } sm510_segments_t;

  // SM5a W and W' arrays, 9 digits of 4 bits
  typedef logic [8:0][3:0] w_array_t;

  // Segment id as produced by the mask image
  typedef struct packed {
    logic [3:0] line_select;
    logic [3:0] column;
    logic [1:0] row;
  } segment_id_t;

endpackage

//--- rtl/gw_input_pkg.sv
package gw_input_pkg;

  // Control codes as stored in the low 7 bits of a config byte
  typedef enum logic [6:0] {
    btn_up      = 7'd0,
    btn_down    = 7'd1,
    btn_left    = 7'd2,
    btn_right   = 7'd3,
    btn_b       = 7'd4,
    btn_a       = 7'd5,
    btn_y       = 7'd6,
    btn_x       = 7'd7,
    btn_trig_l  = 7'd12,
    btn_select  = 7'd13,
    btn_start   = 7'd14,
    btn_trig_r  = 7'd16,
    btn_unused  = 7'd127
  } button_code_e;

  typedef struct packed {
    logic         invert;
    button_code_e code;
  } input_code_t;

  // One word per strobe row, K3 in the top byte
  typedef struct packed {
    input_code_t k3;
    input_code_t k2;
    input_code_t k1;
    input_code_t k0;
  } row_config_t;

  typedef struct packed {
    logic up;
    logic down;
    logic left;
    logic right;
    logic b;
    logic a;
    logic y;
    logic x;
    logic trig_l;
    logic select;
    logic start;
    logic trig_r;
  } buttons_t;

  typedef enum logic [3:0] {
    slot_s0   = 4'd0,
    slot_s1   = 4'd1,
    slot_s2   = 4'd2,
    slot_s3   = 4'd3,
    slot_s4   = 4'd4,
    slot_s5   = 4'd5,
    slot_s6   = 4'd6,
    slot_s7   = 4'd7,
    slot_beta = 4'd8,
    slot_ba   = 4'd9
  } config_slot_e;

  // Empty slot, maps to 0
  localparam input_code_t CODE_UNUSED = '{invert: 1'b0, code: btn_unused};
  localparam row_config_t ROW_UNUSED = '{
    k3: CODE_UNUSED,
    k2: CODE_UNUSED,
    k1: CODE_UNUSED,
    k0: CODE_UNUSED
  };

endpackage
